/* src/mem_cfg.svh */
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// data and address width
`define MEM_XLEN 32

// ram depth in 32-bit words
`define MEM_WORDS 256

// idle cycles between accept and response
`define MEM_RESP_DELAY 1

// trap causes raised by the memory stage
`define MEM_CAUSE_LOAD_FAULT 5
`define MEM_CAUSE_STORE_FAULT 7

`endif

/* src/mem_pkg.sv */
`include "mem_cfg.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_LOAD,
        OP_STORE,
        OP_ATOMIC
    } mem_op_e;

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } mem_size_e;

    typedef enum logic {
        SGN_UNSIGNED,
        SGN_SIGNED
    } sign_e;

    typedef enum logic [3:0] {
        AMO_LR,
        AMO_SC,
        AMO_SWAP,
        AMO_ADD,
        AMO_XOR,
        AMO_AND,
        AMO_OR,
        AMO_MIN,
        AMO_MAX
    } amo_op_e;

    typedef struct packed {
        mem_op_e   op;
        mem_size_e size;
        sign_e     sign;
        amo_op_e   amo;   // only meaningful for OP_ATOMIC
    } mem_ctrl_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] cause;
    } trap_info_t;

    typedef struct packed {
        logic                 valid;
        logic                 wen;
        logic [`MEM_XLEN-1:0] addr;
        logic [`MEM_XLEN-1:0] wdata;
        mem_size_e            size;
    } dreq_t;

    typedef struct packed {
        logic                 valid;
        logic                 error;
        logic [`MEM_XLEN-1:0] rdata;
    } dresp_t;

endpackage

/* src/amo_alu.sv */
`timescale 1ns/100ps

module amo_alu (
    input  mem_pkg::amo_op_e amo,
    input  mem_pkg::sign_e   sign,
    input  logic [31:0]      old_data,
    input  logic [31:0]      rs2_data,
    output logic [31:0]      new_data
);
    import mem_pkg::*;

    logic lt;   // old < rs2

    always_comb begin
        if (sign == SGN_SIGNED) begin
            lt = $signed(old_data) < $signed(rs2_data);
        end else begin
            lt = old_data < rs2_data;
        end
    end

    always_comb begin
        case (amo)
            AMO_ADD: new_data = old_data + rs2_data;
            AMO_XOR: new_data = old_data ^ rs2_data;
            AMO_AND: new_data = old_data & rs2_data;
            AMO_OR:  new_data = old_data | rs2_data;
            AMO_MIN: new_data = lt ? old_data : rs2_data;
            AMO_MAX: new_data = lt ? rs2_data : old_data;
            // swap, and sc stores rs2 as is
            default: new_data = rs2_data;
        endcase
    end

endmodule

/* src/load_format.sv */
`timescale 1ns/100ps

module load_format (
    input  mem_pkg::mem_op_e   op,
    input  mem_pkg::mem_size_e size,
    input  mem_pkg::sign_e     sign,
    input  mem_pkg::amo_op_e   amo,
    input  logic [31:0]        mem_word,
    input  logic               sc_ok,
    output logic [31:0]        result
);
    import mem_pkg::*;

    logic ext_b;
    logic ext_h;

    assign ext_b = (sign == SGN_SIGNED) & mem_word[7];
    assign ext_h = (sign == SGN_SIGNED) & mem_word[15];

    always_comb begin
        result = mem_word;
        if (op == OP_ATOMIC) begin
            // lr and amo return the old word
            if (amo == AMO_SC) begin
                result = sc_ok ? 32'd0 : 32'd1;
            end
        end else begin
            case (size)
                SIZE_B:  result = {{24{ext_b}}, mem_word[7:0]};
                SIZE_H:  result = {{16{ext_h}}, mem_word[15:0]};
                default: result = mem_word;
            endcase
        end
    end

endmodule

/* src/mem_stage.sv */
`timescale 1ns/100ps
`include "mem_cfg.svh"

module mem_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid,
    input  logic                is_new,
    input  mem_pkg::mem_ctrl_t  ctrl,
    input  logic [31:0]         addr,
    input  logic [31:0]         rs2_data,
    input  mem_pkg::trap_info_t trap_in,
    input  logic                ready,
    input  mem_pkg::dresp_t     dresp,
    output mem_pkg::dreq_t      dreq,
    output mem_pkg::trap_info_t trap_out,
    output logic [31:0]         rdata,
    output logic                stall
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_READY,
        S_WAIT_RDATA,
        S_WAIT_WRESP
    } state_e;

    state_e      state;
    logic        done;
    logic        wr_phase;     // next request is a write
    logic        err_q;
    logic        sc_ok;
    logic        resv_valid;
    logic [31:0] resv_addr;
    logic [31:0] saved_word;
    logic [31:0] amo_wdata;

    logic        busy_op;
    logic        done_eff;
    logic        start;
    logic        is_atomic;
    logic        is_rmw;       // amo other than lr/sc
    logic        store_kind;

    assign busy_op   = valid & (ctrl.op != OP_NONE);
    assign done_eff  = done & ~is_new;
    assign start     = busy_op & ~done_eff & (state == S_IDLE);
    assign is_atomic = ctrl.op == OP_ATOMIC;
    assign is_rmw    = is_atomic & (ctrl.amo != AMO_LR) & (ctrl.amo != AMO_SC);
    // sc and amo fault as stores
    assign store_kind = (ctrl.op == OP_STORE) | (is_atomic & (ctrl.amo != AMO_LR));

    assign stall = busy_op & ~done_eff;

    amo_alu i_amo_alu (
        .amo      (ctrl.amo),
        .sign     (ctrl.sign),
        .old_data (saved_word),
        .rs2_data (rs2_data),
        .new_data (amo_wdata)
    );

    load_format i_load_format (
        .op       (ctrl.op),
        .size     (ctrl.size),
        .sign     (ctrl.sign),
        .amo      (ctrl.amo),
        .mem_word (saved_word),
        .sc_ok    (sc_ok),
        .result   (rdata)
    );

    always_comb begin
        dreq.valid = state == S_WAIT_READY;
        dreq.wen   = wr_phase;
        dreq.addr  = addr;
        dreq.wdata = is_atomic ? amo_wdata : rs2_data;
        dreq.size  = is_atomic ? SIZE_W : ctrl.size;
    end

    always_comb begin
        trap_out = trap_in;
        if (ctrl.op != OP_NONE && err_q) begin
            trap_out.valid = 1'b1;
            trap_out.cause = store_kind ? 5'(`MEM_CAUSE_STORE_FAULT)
                                        : 5'(`MEM_CAUSE_LOAD_FAULT);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            done       <= 1'b0;
            wr_phase   <= 1'b0;
            err_q      <= 1'b0;
            sc_ok      <= 1'b0;
            resv_valid <= 1'b0;
        end else begin
            if (is_new) done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        err_q    <= 1'b0;
                        sc_ok    <= 1'b0;
                        wr_phase <= ctrl.op == OP_STORE;
                        state    <= S_WAIT_READY;
                        if (is_atomic && ctrl.amo == AMO_LR) begin
                            resv_valid <= 1'b1;
                        end
                        if (is_atomic && ctrl.amo == AMO_SC) begin
                            resv_valid <= 1'b0;   // any sc drops the reservation
                            if (resv_valid && resv_addr == addr) begin
                                sc_ok    <= 1'b1;
                                wr_phase <= 1'b1;
                            end else begin
                                state <= S_IDLE;
                                done  <= 1'b1;
                            end
                        end
                    end
                end
                S_WAIT_READY: begin
                    if (ready) state <= wr_phase ? S_WAIT_WRESP : S_WAIT_RDATA;
                end
                S_WAIT_RDATA: begin
                    if (dresp.valid) begin
                        if (is_rmw && !dresp.error) begin
                            wr_phase <= 1'b1;     // write back the amo result
                            state    <= S_WAIT_READY;
                        end else begin
                            err_q <= dresp.error;
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end
                    end
                end
                default: begin
                    if (dresp.valid) begin
                        err_q <= dresp.error;
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && is_atomic && ctrl.amo == AMO_LR) resv_addr <= addr;
        if (state == S_WAIT_RDATA && dresp.valid) saved_word <= dresp.rdata;
    end

endmodule

/* src/data_ram.sv */
`timescale 1ns/100ps
`include "mem_cfg.svh"

module data_ram (
    input  logic             clk,
    input  logic             rst,
    input  mem_pkg::dreq_t   dreq,
    output logic             ready,
    output mem_pkg::dresp_t  dresp
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam int CNT_W = $clog2(`MEM_RESP_DELAY + 2);

    logic [31:0]      mem [`MEM_WORDS];
    logic             pend;
    logic [CNT_W-1:0] cnt;
    logic             err_q;
    logic [31:0]      rdata_q;

    logic             accept;
    logic             in_range;
    logic [IDX_W-1:0] idx;
    logic [4:0]       shamt;
    logic [3:0]       lane_en;
    logic [31:0]      wdata_sh;

    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign ready    = ~pend;
    assign accept   = dreq.valid & ready;
    assign idx      = dreq.addr[IDX_W+1:2];
    assign in_range = dreq.addr[31:2] < 30'(`MEM_WORDS);
    assign shamt    = {dreq.addr[1:0], 3'b000};
    assign wdata_sh = dreq.wdata << shamt;

    always_comb begin
        case (dreq.size)
            SIZE_B:  lane_en = 4'b0001 << dreq.addr[1:0];
            SIZE_H:  lane_en = 4'b0011 << dreq.addr[1:0];
            default: lane_en = 4'b1111;
        endcase
    end

    // access happens at accept, the response just waits out the delay
    always_ff @(posedge clk) begin
        if (accept) begin
            err_q   <= ~in_range;
            rdata_q <= in_range ? mem[idx] >> shamt : '0;
            if (dreq.wen && in_range) begin
                for (int i = 0; i < 4; i++) begin
                    if (lane_en[i]) mem[idx][8*i +: 8] <= wdata_sh[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend <= 1'b0;
            cnt  <= '0;
        end else if (accept) begin
            pend <= 1'b1;
            cnt  <= CNT_W'(`MEM_RESP_DELAY);
        end else if (pend) begin
            if (cnt == '0) pend <= 1'b0;   // response cycle
            else cnt <= cnt - 1'b1;
        end
    end

    assign dresp.valid = pend & (cnt == '0);
    assign dresp.error = err_q;
    assign dresp.rdata = rdata_q;

endmodule

/* src/mem_subsys.sv */
`timescale 1ns/100ps

module mem_subsys (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid,
    input  logic                is_new,
    input  mem_pkg::mem_ctrl_t  ctrl,
    input  logic [31:0]         addr,
    input  logic [31:0]         rs2_data,
    input  mem_pkg::trap_info_t trap_in,
    output mem_pkg::trap_info_t trap_out,
    output logic [31:0]         rdata,
    output logic                stall
);
    import mem_pkg::*;

    dreq_t  dreq;
    dresp_t dresp;
    logic   ready;

    mem_stage i_mem_stage (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .is_new   (is_new),
        .ctrl     (ctrl),
        .addr     (addr),
        .rs2_data (rs2_data),
        .trap_in  (trap_in),
        .ready    (ready),
        .dresp    (dresp),
        .dreq     (dreq),
        .trap_out (trap_out),
        .rdata    (rdata),
        .stall    (stall)
    );

    data_ram i_data_ram (
        .clk   (clk),
        .rst   (rst),
        .dreq  (dreq),
        .ready (ready),
        .dresp (dresp)
    );

endmodule

/* dv/mem_subsys_tb.sv */
`timescale 1ns/100ps
`include "mem_cfg.svh"

module mem_subsys_tb;
    import mem_pkg::*;

    localparam int BYTES = `MEM_WORDS * 4;
    localparam int AW = $clog2(BYTES);

    logic        clk;
    logic        rst;
    logic        valid;
    logic        is_new;
    mem_ctrl_t   ctrl;
    logic [31:0] addr;
    logic [31:0] rs2_data;
    trap_info_t  trap_in;
    trap_info_t  trap_out;
    logic [31:0] rdata;
    logic        stall;

    logic [7:0]  ref_mem [BYTES];
    logic        ref_resv;
    logic [31:0] ref_resv_addr;
    integer      seed;
    int          errors;
    int          checks;
    int          last_cycles;   // cycles until stall dropped

    mem_subsys i_mem_subsys (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] word_at(input logic [31:0] a);
        logic [31:0] w;
        logic [31:0] p;
        for (int i = 0; i < 4; i++) begin
            p = a + 32'(i);
            w[8*i +: 8] = ref_mem[p[AW-1:0]];
        end
        return w;
    endfunction

    function automatic void put_bytes(input logic [31:0] a, input logic [31:0] d, input int n);
        logic [31:0] p;
        for (int i = 0; i < n; i++) begin
            p = a + 32'(i);
            ref_mem[p[AW-1:0]] = d[8*i +: 8];
        end
    endfunction

    function automatic logic [31:0] amo_result(input amo_op_e op, input sign_e sg,
                                               input logic [31:0] old, input logic [31:0] src);
        logic signed [32:0] so;
        logic signed [32:0] ss;
        // 33 bits give one compare for both orders
        so = {sg == SGN_SIGNED && old[31], old};
        ss = {sg == SGN_SIGNED && src[31], src};
        case (op)
            AMO_ADD: return old + src;
            AMO_XOR: return old ^ src;
            AMO_AND: return old & src;
            AMO_OR:  return old | src;
            AMO_MIN: return (so < ss) ? old : src;
            AMO_MAX: return (so > ss) ? old : src;
            default: return src;   // swap
        endcase
    endfunction

    // expected rdata and trap_out, and the model update
    function automatic void model_op(input mem_ctrl_t c, input logic [31:0] a,
                                     input logic [31:0] d, output logic [31:0] e_rdata,
                                     output trap_info_t e_trap, output logic chk);
        logic               ok;
        logic               load_kind;
        logic [31:0]        w;
        logic signed [7:0]  sb;
        logic signed [15:0] sh;
        ok = a < 32'(BYTES);
        w = word_at(a);
        sb = w[7:0];
        sh = w[15:0];
        e_rdata = w;
        e_trap = trap_in;
        load_kind = c.op == OP_LOAD || (c.op == OP_ATOMIC && c.amo == AMO_LR);
        if (c.op == OP_LOAD && c.size == SIZE_B) begin
            if (c.sign == SGN_SIGNED) e_rdata = 32'(sb);
            else e_rdata = {24'd0, w[7:0]};
        end else if (c.op == OP_LOAD && c.size == SIZE_H) begin
            if (c.sign == SGN_SIGNED) e_rdata = 32'(sh);
            else e_rdata = {16'd0, w[15:0]};
        end else if (c.op == OP_STORE && ok) begin
            put_bytes(a, d, c.size == SIZE_B ? 1 : (c.size == SIZE_H ? 2 : 4));
        end else if (c.op == OP_ATOMIC) begin
            case (c.amo)
                AMO_LR: begin
                    ref_resv = 1'b1;
                    ref_resv_addr = a;
                end
                AMO_SC: begin
                    if (ref_resv && ref_resv_addr == a) begin
                        e_rdata = 32'd0;
                        if (ok) put_bytes(a, d, 4);
                    end else begin
                        e_rdata = 32'd1;
                        ok = 1'b1;   // no request goes out
                    end
                    ref_resv = 1'b0;
                end
                default: begin
                    if (ok) put_bytes(a, amo_result(c.amo, c.sign, w, d), 4);
                end
            endcase
        end
        chk = ok && c.op != OP_STORE && c.op != OP_NONE;
        if (!ok && c.op != OP_NONE) begin
            e_trap.valid = 1'b1;
            e_trap.cause = load_kind ? 5'(`MEM_CAUSE_LOAD_FAULT) : 5'(`MEM_CAUSE_STORE_FAULT);
        end
    endfunction

    task automatic compare(input logic [31:0] e_rdata, input trap_info_t e_trap, input logic chk);
        checks++;
        if (trap_out !== e_trap) begin
            errors++;
            $display("mismatch at %0t: trap_out expected %h got %h", $time, e_trap, trap_out);
        end
        if (chk && rdata !== e_rdata) begin
            errors++;
            $display("mismatch at %0t: rdata expected %h got %h", $time, e_rdata, rdata);
        end
    endtask

    task automatic run_op(input mem_op_e op, input mem_size_e sz, input sign_e sg,
                          input amo_op_e amo, input logic [31:0] a, input logic [31:0] d);
        logic [31:0] e_rdata;
        trap_info_t  e_trap;
        logic        chk;
        int          n;
        @(negedge clk);
        valid     = 1'b1;
        is_new    = 1'b1;
        ctrl.op   = op;
        ctrl.size = sz;
        ctrl.sign = sg;
        ctrl.amo  = amo;
        addr      = a;
        rs2_data  = d;
        trap_in   = trap_info_t'(6'($random(seed)));
        model_op(ctrl, a, d, e_rdata, e_trap, chk);
        n = 0;
        #10;
        while (stall && n < 50) begin
            @(negedge clk);
            is_new = 1'b0;
            #10;
            n++;
        end
        last_cycles = n;
        if (stall) begin
            errors++;
            $display("timeout at %0t: stage never finished op %0d at address %h", $time, op, a);
        end else begin
            compare(e_rdata, e_trap, chk);
        end
    endtask

    task automatic report(input string name, input int e0);
        if (errors == e0) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, errors - e0);
        end
    endtask

    initial begin
        int          e0;
        int          k;
        logic [31:0] a;
        logic [31:0] r;
        mem_size_e   sz;
        seed = 66089;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        valid = 1'b0;
        is_new = 1'b0;
        ctrl = '0;
        addr = '0;
        rs2_data = '0;
        trap_in = '0;
        ref_resv = 1'b0;
        ref_resv_addr = '0;
        for (int i = 0; i < BYTES; i++) ref_mem[i] = 8'h00;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        e0 = errors;
        run_op(OP_STORE, SIZE_W, SGN_UNSIGNED, AMO_LR, 32'h40, 32'h8091_a2f3);
        run_op(OP_STORE, SIZE_H, SGN_UNSIGNED, AMO_LR, 32'h46, 32'h1234_c0de);
        run_op(OP_STORE, SIZE_B, SGN_UNSIGNED, AMO_LR, 32'h45, 32'h5566_7785);
        for (int i = 0; i < 8; i++) begin
            a = 32'h40 + 32'(i);
            run_op(OP_LOAD, SIZE_B, SGN_SIGNED, AMO_LR, a, 32'd0);
            run_op(OP_LOAD, SIZE_B, SGN_UNSIGNED, AMO_LR, a, 32'd0);
            if (i % 2 == 0) begin
                run_op(OP_LOAD, SIZE_H, SGN_SIGNED, AMO_LR, a, 32'd0);
                run_op(OP_LOAD, SIZE_H, SGN_UNSIGNED, AMO_LR, a, 32'd0);
            end
            if (i % 4 == 0) run_op(OP_LOAD, SIZE_W, SGN_UNSIGNED, AMO_LR, a, 32'd0);
        end
        report("stores_loads", e0);

        e0 = errors;
        for (int op = 2; op <= 8; op++) begin
            for (int s = 0; s < 2; s++) begin
                a = 32'h80 + 32'(op * 8 + s * 4);
                run_op(OP_STORE, SIZE_W, SGN_UNSIGNED, AMO_LR, a, $random(seed));
                run_op(OP_ATOMIC, SIZE_W, sign_e'(1'(s)), amo_op_e'(4'(op)), a, $random(seed));
                run_op(OP_LOAD, SIZE_W, SGN_UNSIGNED, AMO_LR, a, 32'd0);
            end
        end
        report("amo", e0);

        e0 = errors;
        run_op(OP_ATOMIC, SIZE_W, SGN_SIGNED, AMO_LR, 32'h100, 32'd0);
        run_op(OP_ATOMIC, SIZE_W, SGN_SIGNED, AMO_SC, 32'h100, 32'h1111_2222);
        run_op(OP_ATOMIC, SIZE_W, SGN_SIGNED, AMO_SC, 32'h100, 32'h3333_4444);
        run_op(OP_LOAD, SIZE_W, SGN_UNSIGNED, AMO_LR, 32'h100, 32'd0);
        run_op(OP_ATOMIC, SIZE_W, SGN_SIGNED, AMO_LR, 32'h104, 32'd0);
        run_op(OP_ATOMIC, SIZE_W, SGN_SIGNED, AMO_SC, 32'h108, 32'h5555_6666);
        run_op(OP_LOAD, SIZE_W, SGN_UNSIGNED, AMO_LR, 32'h108, 32'd0);
        report("reservation", e0);

        e0 = errors;
        run_op(OP_LOAD, SIZE_W, SGN_UNSIGNED, AMO_LR, 32'h400, 32'd0);
        run_op(OP_ATOMIC, SIZE_W, SGN_SIGNED, AMO_LR, 32'h404, 32'd0);
        run_op(OP_STORE, SIZE_W, SGN_UNSIGNED, AMO_LR, 32'h400, 32'hdead_beef);
        run_op(OP_ATOMIC, SIZE_W, SGN_SIGNED, AMO_SC, 32'h404, 32'hdead_beef);
        run_op(OP_ATOMIC, SIZE_W, SGN_SIGNED, AMO_ADD, 32'h1000, 32'd7);
        run_op(OP_LOAD, SIZE_W, SGN_UNSIGNED, AMO_LR, 32'h0, 32'd0);
        run_op(OP_LOAD, SIZE_W, SGN_UNSIGNED, AMO_LR, 32'h4, 32'd0);
        report("faults", e0);

        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            run_op(OP_NONE, SIZE_W, SGN_UNSIGNED, AMO_LR, 32'h400, 32'd0);
            if (last_cycles != 0) begin
                errors++;
                $display("stall was raised for an op of none at %0t", $time);
            end
        end
        run_op(OP_LOAD, SIZE_W, SGN_UNSIGNED, AMO_LR, 32'h40, 32'd0);
        if (last_cycles != `MEM_RESP_DELAY + 3) begin
            errors++;
            $display("mismatch at %0t: load latency expected %0d got %0d",
                     $time, `MEM_RESP_DELAY + 3, last_cycles);
        end
        report("passthrough", e0);

        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            k = $unsigned($random(seed)) % 6;
            r = $random(seed);
            sz = mem_size_e'(2'(r[7:0] % 8'd3));
            a = 32'h200 + 32'(r[12:8]);
            if (k >= 2 || sz == SIZE_W) a[1:0] = 2'b00;
            else if (sz == SIZE_H) a[0] = 1'b0;
            case (k)
                0: run_op(OP_LOAD, sz, sign_e'(r[13]), AMO_LR, a, 32'd0);
                1: run_op(OP_STORE, sz, SGN_UNSIGNED, AMO_LR, a, $random(seed));
                2: run_op(OP_ATOMIC, SIZE_W, SGN_UNSIGNED, AMO_LR, a, 32'd0);
                3: run_op(OP_ATOMIC, SIZE_W, SGN_UNSIGNED, AMO_SC, a, $random(seed));
                4: run_op(OP_ATOMIC, SIZE_W, sign_e'(r[13]),
                          amo_op_e'(4'(2 + r[16:14] % 3'd7)), a, $random(seed));
                default: run_op(OP_NONE, sz, SGN_UNSIGNED, AMO_LR, a, 32'd0);
            endcase
        end
        report("random", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+src
src/mem_pkg.sv
src/amo_alu.sv
src/load_format.sv
src/mem_stage.sv
src/data_ram.sv
src/mem_subsys.sv
dv/mem_subsys_tb.sv

/* Makefile */
# Verilator flow for the memory subsystem

TB_TOP := mem_subsys_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module mem_subsys

# pass only if the testbench prints the pass line
sim:
	verilator --binary --timing -f project.f --top-module $(TB_TOP)
	@out="$$(./obj_dir/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
